/* Makefile */
VERILATOR  ?= verilator
FILELIST   := sources.f
TB_TOP     := tb_op_only_rs
RTL_TOP    := op_only_rs_top
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* source/cdb_rr_arbiter.sv */
// Two-way CDB arbiter; a stalled winner is held until accepted, priority starts at the station
`timescale 1ns/1ps

module cdb_rr_arbiter (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Station source
    input  logic                rs_req_i,
    input  oprs_pkg::cdb_data_t rs_data_i,

    // External unit source
    input  logic                eu_valid_i,
    input  oprs_pkg::cdb_data_t eu_data_i,

    // CDB side
    input  logic                cdb_ready_i,
    output logic                rs_grant_o,
    output logic                eu_ready_o,
    output logic                cdb_valid_o,
    output oprs_pkg::cdb_data_t cdb_data_o
);
    import oprs_pkg::*;

    logic eu_prio_q;
    logic lock_q;
    logic lock_rs_q;
    logic pick_rs;
    logic accept;

    // --------------------------------------------------
    // Winner selection
    // --------------------------------------------------
    always_comb begin
        // Keep last cycle's stalled winner so the bus stays stable
        if (lock_q && (lock_rs_q ? rs_req_i : eu_valid_i)) begin
            pick_rs = lock_rs_q;
        end else if (rs_req_i && eu_valid_i) begin
            pick_rs = ~eu_prio_q;
        end else begin
            pick_rs = rs_req_i;
        end
    end

    assign cdb_valid_o = rs_req_i | eu_valid_i;
    assign cdb_data_o  = pick_rs ? rs_data_i : eu_data_i;
    assign accept      = cdb_valid_o & cdb_ready_i;
    assign rs_grant_o  = pick_rs & rs_req_i & cdb_ready_i;
    assign eu_ready_o  = ~pick_rs & eu_valid_i & cdb_ready_i;

    // Loser of the last accepted transfer goes first next time
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            eu_prio_q <= 1'b0;
            lock_q    <= 1'b0;
            lock_rs_q <= 1'b0;
        end else begin
            if (accept) begin
                eu_prio_q <= pick_rs;
            end
            lock_q    <= cdb_valid_o & ~cdb_ready_i;
            lock_rs_q <= pick_rs;
        end
    end

endmodule

/* source/op_only_rs_top.sv */
// Operand-only station with CDB arbiter; only accepted broadcasts reach the snoop port
`timescale 1ns/1ps

module op_only_rs_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // Issue port
    input  logic                 issue_valid_i,
    output logic                 issue_ready_o,
    input  oprs_pkg::issue_req_t issue_i,

    // External execution unit
    input  logic                 eu_valid_i,
    output logic                 eu_ready_o,
    input  oprs_pkg::cdb_data_t  eu_data_i,

    // Common data bus
    output logic                 cdb_valid_o,
    input  logic                 cdb_ready_i,
    output oprs_pkg::cdb_data_t  cdb_data_o
);
    import oprs_pkg::*;

    rs_mask_t  valid_vec;
    rs_mask_t  ready_vec;
    cdb_data_t head_data;
    logic      push;
    logic      pop;
    rs_idx_t   tail_idx;
    rs_idx_t   head_idx;
    logic      rs_req;
    logic      rs_grant;
    logic      cdb_fire;

    // Feedback of the accepted broadcast
    assign cdb_fire = cdb_valid_o & cdb_ready_i;

    // --------------------------------------------------
    // Instances
    // --------------------------------------------------
    oprs_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .valid_vec_i   (valid_vec),
        .ready_vec_i   (ready_vec),
        .rs_grant_i    (rs_grant),
        .push_o        (push),
        .pop_o         (pop),
        .tail_idx_o    (tail_idx),
        .head_idx_o    (head_idx),
        .rs_req_o      (rs_req)
    );

    oprs_entry_array u_entries (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .push_i        (push),
        .pop_i         (pop),
        .tail_idx_i    (tail_idx),
        .head_idx_i    (head_idx),
        .issue_i       (issue_i),
        .snoop_valid_i (cdb_fire),
        .snoop_i       (cdb_data_o),
        .valid_vec_o   (valid_vec),
        .ready_vec_o   (ready_vec),
        .head_data_o   (head_data)
    );

    cdb_rr_arbiter u_arb (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rs_req_i      (rs_req),
        .rs_data_i     (head_data),
        .eu_valid_i    (eu_valid_i),
        .eu_data_i     (eu_data_i),
        .cdb_ready_i   (cdb_ready_i),
        .rs_grant_o    (rs_grant),
        .eu_ready_o    (eu_ready_o),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_data_o    (cdb_data_o)
    );

endmodule

/* source/oprs_ctrl.sv */
// Pointer control; full is seen through the tail slot valid bit, flush wins over push and pop
`timescale 1ns/1ps

module oprs_ctrl (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              flush_i,

    // Issue side handshake
    input  logic              issue_valid_i,
    output logic              issue_ready_o,

    // Status from the entry array
    input  oprs_pkg::rs_mask_t valid_vec_i,
    input  oprs_pkg::rs_mask_t ready_vec_i,

    // Grant back from the CDB arbiter
    input  logic              rs_grant_i,

    // Array controls
    output logic              push_o,
    output logic              pop_o,
    output oprs_pkg::rs_idx_t tail_idx_o,
    output oprs_pkg::rs_idx_t head_idx_o,

    // Request towards the arbiter
    output logic              rs_req_o
);
    import oprs_pkg::*;

    rs_idx_t head_q;
    rs_idx_t tail_q;

    // --------------------------------------------------
    // Push and pop decisions
    // --------------------------------------------------
    always_comb begin
        // Free tail slot means room for one more
        issue_ready_o = ~valid_vec_i[tail_q];
        push_o        = issue_ready_o & issue_valid_i;

        // Only the head may broadcast to keep issue order
        rs_req_o      = valid_vec_i[head_q] & ready_vec_i[head_q];

        // Grant already includes cdb_ready_i
        pop_o         = rs_grant_i;
    end

    // --------------------------------------------------
    // Head and tail pointers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            // Queue restarts from slot zero
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push_o) begin
                tail_q <= tail_q + rs_idx_t'(1);
            end
            if (pop_o) begin
                head_q <= head_q + rs_idx_t'(1);
            end
        end
    end

    assign tail_idx_o = tail_q;
    assign head_idx_o = head_q;

endmodule

/* source/oprs_entry_array.sv */
// Entry storage; a push whose tag is on the accepted CDB in the same cycle captures it directly
`timescale 1ns/1ps

module oprs_entry_array (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    // Controls from the pointer logic
    input  logic                 push_i,
    input  logic                 pop_i,
    input  oprs_pkg::rs_idx_t    tail_idx_i,
    input  oprs_pkg::rs_idx_t    head_idx_i,

    // New instruction
    input  oprs_pkg::issue_req_t issue_i,

    // Accepted CDB broadcast for wake-up
    input  logic                 snoop_valid_i,
    input  oprs_pkg::cdb_data_t  snoop_i,

    // Status and head result
    output oprs_pkg::rs_mask_t   valid_vec_o,
    output oprs_pkg::rs_mask_t   ready_vec_o,
    output oprs_pkg::cdb_data_t  head_data_o
);
    import oprs_pkg::*;

    // Occupancy and operand state
    rs_mask_t  valid_q;
    rs_mask_t  ready_q;

    // Payload per slot
    rob_idx_t  rs1_idx_q   [RS_DEPTH];
    xlen_t     rs1_value_q [RS_DEPTH];
    rob_idx_t  dest_idx_q  [RS_DEPTH];

    // Assembled view of each slot
    rs_entry_t entries     [RS_DEPTH];
    rs_mask_t  wake_vec;
    logic      snoop_ok;
    logic      push_hit;

    // Exceptional results never wake anybody
    assign snoop_ok = snoop_valid_i & ~snoop_i.except_raised;
    assign push_hit = snoop_ok & ~issue_i.rs1_ready & (issue_i.rs1_idx == snoop_i.rob_idx);

    // --------------------------------------------------
    // Slot view and parallel tag compare
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entries[i].valid     = valid_q[i];
            entries[i].rs1_ready = ready_q[i];
            entries[i].rs1_idx   = rs1_idx_q[i];
            entries[i].rs1_value = rs1_value_q[i];
            entries[i].dest_idx  = dest_idx_q[i];
            // Waiting slot with matching tag
            wake_vec[i] = snoop_ok & entries[i].valid & ~entries[i].rs1_ready
                        & (entries[i].rs1_idx == snoop_i.rob_idx);
        end
    end

    // --------------------------------------------------
    // Control bits
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            ready_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            ready_q <= ready_q | wake_vec;
            // Push targets an empty slot and never the popped head
            if (push_i) begin
                valid_q[tail_idx_i] <= 1'b1;
                ready_q[tail_idx_i] <= issue_i.rs1_ready | push_hit;
            end
            if (pop_i) begin
                valid_q[head_idx_i] <= 1'b0;
                ready_q[head_idx_i] <= 1'b0;
            end
        end
    end

    // Payload writes
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake_vec[i]) begin
                rs1_value_q[i] <= snoop_i.value;
            end
        end
        if (push_i) begin
            rs1_idx_q[tail_idx_i]   <= issue_i.rs1_idx;
            rs1_value_q[tail_idx_i] <= push_hit ? snoop_i.value : issue_i.rs1_value;
            dest_idx_q[tail_idx_i]  <= issue_i.dest_idx;
        end
    end

    // Head result carries no exception
    always_comb begin
        head_data_o.rob_idx       = entries[head_idx_i].dest_idx;
        head_data_o.value         = entries[head_idx_i].rs1_value;
        head_data_o.except_raised = 1'b0;
        head_data_o.except_code   = '0;
    end

    assign valid_vec_o = valid_q;
    assign ready_vec_o = ready_q;

endmodule

/* source/oprs_pkg.sv */
// Shared types for the operand-only station; RS_DEPTH must be a power of two, entries are FIFO

package oprs_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int XLEN        = 32;
    localparam int ROB_DEPTH   = 16;
    localparam int ROB_IDX_LEN = $clog2(ROB_DEPTH);
    localparam int EXCEPT_LEN  = 4;

    // Station depth where pointers wrap by plain overflow
    localparam int RS_DEPTH    = 4;
    localparam int RS_IDX_LEN  = $clog2(RS_DEPTH);

    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;
    typedef logic [RS_IDX_LEN-1:0]  rs_idx_t;
    typedef logic [RS_DEPTH-1:0]    rs_mask_t;
    typedef logic [EXCEPT_LEN-1:0]  except_code_t;

    // --------------------------------------------------
    // Bus and entry structs
    // --------------------------------------------------
    // One result on the common data bus
    typedef struct packed {
        rob_idx_t     rob_idx;
        xlen_t        value;
        logic         except_raised;
        except_code_t except_code;
    } cdb_data_t;

    // Instruction as handed over by the issue stage
    typedef struct packed {
        logic     rs1_ready;
        rob_idx_t rs1_idx;
        xlen_t    rs1_value;
        rob_idx_t dest_idx;
    } issue_req_t;

    // Station slot with issue fields plus occupancy
    typedef struct packed {
        logic     valid;
        logic     rs1_ready;
        rob_idx_t rs1_idx;
        xlen_t    rs1_value;
        rob_idx_t dest_idx;
    } rs_entry_t;

endpackage

/* sources.f */
source/oprs_pkg.sv
source/oprs_ctrl.sv
source/oprs_entry_array.sv
source/cdb_rr_arbiter.sv
source/op_only_rs_top.sv
testbench/op_only_rs_properties.sv
testbench/tb_op_only_rs.sv

/* testbench/op_only_rs_properties.sv */
// Bound checks on the station top; assumes the stall holds no flush while cdb_ready_i is low
`timescale 1ns/1ps

module op_only_rs_properties (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                flush_i,
    input logic                cdb_valid_i,
    input logic                cdb_ready_i,
    input oprs_pkg::cdb_data_t cdb_data_i,
    input logic                push_i,
    input logic                pop_i,
    input oprs_pkg::rs_mask_t  valid_vec_i,
    input logic                rs_grant_i,
    input logic                eu_ready_i
);

    // --------------------------------------------------
    // Handshake rules
    // --------------------------------------------------
    // Stalled bus keeps valid and data
    stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($past(cdb_valid_i) && !$past(cdb_ready_i))
            |-> (cdb_valid_i && (cdb_data_i == $past(cdb_data_i))))
        else $error("CDB valid or data changed while the bus was stalled");

    // Exactly one grant for each accepted broadcast
    grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rs_grant_i && eu_ready_i)
            && ((rs_grant_i || eu_ready_i) == (cdb_valid_i && cdb_ready_i)))
        else $error("grants do not match the accepted CDB transfer");

    // --------------------------------------------------
    // Pointer rules
    // --------------------------------------------------
    // A push must land in a free slot so a full queue cannot take one
    no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (push_i && !pop_i && !flush_i)
            |=> ($countones(valid_vec_i) == $past($countones(valid_vec_i)) + 1))
        else $error("push did not add an entry to the queue");

endmodule

bind op_only_rs_top op_only_rs_properties u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .cdb_valid_i (cdb_valid_o),
    .cdb_ready_i (cdb_ready_i),
    .cdb_data_i  (cdb_data_o),
    .push_i      (push),
    .pop_i       (pop),
    .valid_vec_i (valid_vec),
    .rs_grant_i  (rs_grant),
    .eu_ready_i  (eu_ready_o)
);

/* testbench/tb_op_only_rs.sv */
// Table-driven test against a queue model; assumes FIFO order, inputs driven 2 ns after posedge
`timescale 1ns/1ps

module tb_op_only_rs;
    import oprs_pkg::*;

    // Table plus drain needs well under 100 cycles
    localparam int         CYCLE_LIMIT = 2000;
    localparam logic [1:0] DC          = 2'd2;

    // One step of stimulus
    // An exp_ir of DC leaves issue_ready_o unchecked
    typedef struct packed {
        logic       iss;
        logic       rdy;
        rob_idx_t   rs1_idx;
        rob_idx_t   dest;
        logic       eu;
        rob_idx_t   eu_idx;
        logic       eu_exc;
        logic       cdb_rdy;
        logic       flush;
        logic [1:0] exp_ir;
    } row_t;

    logic       clk_i;
    logic       rst_n_i;
    logic       flush_i;
    logic       issue_valid_i;
    logic       issue_ready_o;
    issue_req_t issue_i;
    logic       eu_valid_i;
    logic       eu_ready_o;
    cdb_data_t  eu_data_i;
    logic       cdb_valid_o;
    logic       cdb_ready_i;
    cdb_data_t  cdb_data_o;

    integer     seed = 32'ha92f58d6;
    int         cycle_count = 0;
    int         error_count = 0;
    row_t       rows[$];
    row_t       idle_row;

    // Offers waiting for their handshake
    issue_req_t issue_pend[$];
    cdb_data_t  eu_pend[$];

    // Reference queue in issue order, arbiter turn and stall hold
    rs_entry_t  model_q[$];
    logic       eu_turn = 1'b0;
    logic       held = 1'b0;
    logic       held_rs = 1'b0;

    op_only_rs_top u_op_only_rs_top (.*);

    always #20 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] expv);
        assert (got === expv) else begin
            error_count = error_count + 1;
            $display("error at %0t ns: %s expected %h, got %h", $time, what, expv, got);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic add_row(input int iss, input int rdy, input int rs1_idx, input int dest,
                           input int eu, input int eu_idx, input int eu_exc,
                           input int cdb_rdy, input int flush, input int exp_ir);
        row_t r;
        r.iss     = (iss != 0);
        r.rdy     = (rdy != 0);
        r.rs1_idx = rob_idx_t'(rs1_idx);
        r.dest    = rob_idx_t'(dest);
        r.eu      = (eu != 0);
        r.eu_idx  = rob_idx_t'(eu_idx);
        r.eu_exc  = (eu_exc != 0);
        r.cdb_rdy = (cdb_rdy != 0);
        r.flush   = (flush != 0);
        r.exp_ir  = 2'(exp_ir);
        rows.push_back(r);
    endtask

    task automatic idle_rows(input int cdb_rdy, input int count);
        for (int i = 0; i < count; i++) begin
            add_row(0, 0, 0, 0, 0, 0, 0, cdb_rdy, 0, DC);
        end
    endtask

    // --------------------------------------------------
    // Reference model evaluated between edges
    // --------------------------------------------------
    task automatic model_step();
        logic      rs_req;
        logic      eu_req;
        logic      exp_valid;
        logic      pick_rs;
        logic      accept;
        logic      do_push;
        cdb_data_t exp_data;
        rs_entry_t ent;
        rs_req    = (model_q.size() > 0) && model_q[0].rs1_ready;
        eu_req    = eu_valid_i;
        exp_valid = rs_req | eu_req;
        // Stalled winner keeps the bus, else the loser of the last transfer goes first
        if (held && (held_rs ? rs_req : eu_req)) begin
            pick_rs = held_rs;
        end else if (rs_req && eu_req) begin
            pick_rs = ~eu_turn;
        end else begin
            pick_rs = rs_req;
        end
        exp_data = eu_data_i;
        if (pick_rs) begin
            exp_data = '{rob_idx: model_q[0].dest_idx, value: model_q[0].rs1_value,
                         except_raised: 1'b0, except_code: '0};
        end
        accept  = exp_valid & cdb_ready_i;
        do_push = issue_valid_i && (model_q.size() < RS_DEPTH);

        expect_eq("issue_ready_o", 64'(issue_ready_o), 64'(model_q.size() < RS_DEPTH));
        expect_eq("cdb_valid_o", 64'(cdb_valid_o), 64'(exp_valid));
        expect_eq("eu_ready_o", 64'(eu_ready_o), 64'(~pick_rs & eu_req & cdb_ready_i));
        if (exp_valid) begin
            expect_eq("cdb_data_o", 64'(cdb_data_o), 64'(exp_data));
        end

        if (accept && !pick_rs) begin
            void'(eu_pend.pop_front());
        end
        if (do_push) begin
            void'(issue_pend.pop_front());
        end
        if (flush_i) begin
            model_q.delete();
        end else begin
            if (accept && pick_rs) begin
                void'(model_q.pop_front());
            end
            // Wake-up from the accepted broadcast ignores exceptions
            for (int i = 0; i < model_q.size(); i++) begin
                if (accept && !exp_data.except_raised && !model_q[i].rs1_ready
                        && model_q[i].rs1_idx == exp_data.rob_idx) begin
                    model_q[i].rs1_ready = 1'b1;
                    model_q[i].rs1_value = exp_data.value;
                end
            end
            if (do_push) begin
                ent = {1'b1, issue_i};
                if (accept && !exp_data.except_raised && !ent.rs1_ready
                        && ent.rs1_idx == exp_data.rob_idx) begin
                    ent.rs1_ready = 1'b1;
                    ent.rs1_value = exp_data.value;
                end
                model_q.push_back(ent);
            end
        end
        if (accept) begin
            eu_turn = pick_rs;
        end
        held    = exp_valid & ~cdb_ready_i;
        held_rs = pick_rs;
    endtask

    task automatic apply_row(input row_t r);
        issue_req_t req;
        cdb_data_t  res;
        @(posedge clk_i);
        #2;
        if (r.iss) begin
            req.rs1_ready = r.rdy;
            req.rs1_idx   = r.rs1_idx;
            req.rs1_value = $random(seed);
            req.dest_idx  = r.dest;
            issue_pend.push_back(req);
        end
        if (r.eu) begin
            res.rob_idx       = r.eu_idx;
            res.value         = $random(seed);
            res.except_raised = r.eu_exc;
            res.except_code   = r.eu_exc ? 4'h5 : 4'h0;
            eu_pend.push_back(res);
        end
        // Offers stay on the port until their handshake
        issue_valid_i = (issue_pend.size() > 0);
        issue_i       = (issue_pend.size() > 0) ? issue_pend[0] : '0;
        eu_valid_i    = (eu_pend.size() > 0);
        eu_data_i     = (eu_pend.size() > 0) ? eu_pend[0] : '0;
        cdb_ready_i   = r.cdb_rdy;
        flush_i       = r.flush;
        @(negedge clk_i);
        if (r.exp_ir != DC) begin
            expect_eq("issue_ready_o from table", 64'(issue_ready_o), 64'(r.exp_ir));
        end
        model_step();
    endtask

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    task automatic build_table();
        // Both sources contend and the station wins first after reset
        add_row(1, 1, 0, 1, 0, 0, 0, 1, 0, 1);
        add_row(1, 1, 0, 2, 1, 12, 0, 1, 0, DC);
        add_row(1, 1, 0, 3, 1, 13, 0, 1, 0, DC);
        add_row(0, 0, 0, 0, 1, 14, 0, 1, 0, DC);
        idle_rows(1, 6);
        // Ready operands in issue order
        add_row(1, 1, 0, 1, 0, 0, 0, 1, 0, 1);
        add_row(1, 1, 0, 2, 0, 0, 0, 1, 0, DC);
        add_row(1, 1, 0, 3, 0, 0, 0, 1, 0, DC);
        idle_rows(1, 4);
        // Waiting head blocks two ready ones until tag 9 arrives
        add_row(1, 0, 9, 4, 0, 0, 0, 1, 0, DC);
        add_row(1, 1, 0, 5, 0, 0, 0, 1, 0, DC);
        add_row(1, 1, 0, 6, 0, 0, 0, 1, 0, DC);
        idle_rows(1, 2);
        add_row(0, 0, 0, 0, 1, 9, 0, 1, 0, DC);
        idle_rows(1, 5);
        // Exceptional tag 10 leaves the entry waiting until the flush
        add_row(1, 0, 10, 7, 0, 0, 0, 1, 0, DC);
        add_row(0, 0, 0, 0, 1, 10, 1, 1, 0, DC);
        idle_rows(1, 3);
        add_row(1, 1, 0, 8, 0, 0, 0, 1, 0, DC);
        idle_rows(1, 2);
        add_row(0, 0, 0, 0, 0, 0, 0, 1, 1, DC);
        add_row(0, 0, 0, 0, 1, 10, 0, 1, 0, 1);
        idle_rows(1, 4);
        // Fill under back-pressure until the fifth offer waits
        add_row(1, 1, 0, 11, 0, 0, 0, 0, 0, 1);
        add_row(1, 1, 0, 12, 0, 0, 0, 0, 0, 1);
        add_row(1, 1, 0, 13, 0, 0, 0, 0, 0, 1);
        add_row(1, 1, 0, 14, 0, 0, 0, 0, 0, 1);
        add_row(1, 1, 0, 15, 0, 0, 0, 0, 0, 0);
        idle_rows(0, 3);
        idle_rows(1, 8);
    endtask

    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        eu_valid_i    = 1'b0;
        eu_data_i     = '0;
        cdb_ready_i   = 1'b0;
        idle_row      = '0;
        idle_row.cdb_rdy = 1'b1;
        idle_row.exp_ir  = DC;
        build_table();
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        // Drain whatever is still queued or offered
        while (model_q.size() > 0 || issue_pend.size() > 0 || eu_pend.size() > 0) begin
            apply_row(idle_row);
        end
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule
